/* mmu_top.f */
source/mmu_pkg.sv
source/region_match.sv
source/cp15_regs.sv
source/abort_unit.sv
source/line_fill.sv
source/mmu_top.sv
verification/mmu_top_tb.sv

/* Bender.yml */
package:
  name: mmu_top

sources:
  - source/mmu_pkg.sv
  - source/region_match.sv
  - source/cp15_regs.sv
  - source/abort_unit.sv
  - source/line_fill.sv
  - source/mmu_top.sv
  - target: test
    files:
      - verification/mmu_top_tb.sv

/* verification/mmu_vectors.txt */
// Columns: op arg_a arg_b expect, 1=wr addr data resp, 2=rd addr data resp, 3=big_end - - flag
// 4=imiss ia miss iabort, 5=dmiss da miss dabort, 6=fetch ia - use_mini, 7=fill addr - aborted, 0=end
00000002 00000000 ED019ED0 00000000
00000001 00000000 12345678 00000000
00000002 00000000 ED019ED0 00000000
00000001 00000024 00000001 00000002
00000002 00000024 00000000 00000002
00000001 00000008 00100001 00000000
00000001 0000000C 02000004 00000000
00000001 00000010 4000000F 00000000
00000001 00000014 00008002 00000000
00000002 00000008 00100001 00000000
00000002 0000000C 02000004 00000000
00000002 00000010 4000000F 00000000
00000002 00000014 00008002 00000000
00000001 00000004 00000080 00000000
00000003 00000000 00000000 00000001
00000001 00000004 00000000 00000000
00000003 00000000 00000000 00000000
00000001 00000004 00002000 00000000
00000004 00100FFC 00000001 00000001
00000004 00100000 00000001 00000001
00000004 00101000 00000001 00000000
00000004 00100800 00000000 00000000
00000005 00100A34 00000001 00000001
00000002 00000038 00100A34 00000000
00000005 00101000 00000001 00000000
00000001 00000038 FFFFFFFF 00000000
00000002 00000038 00100A34 00000000
00000006 000080C0 00000000 00000000
00000001 00000004 00012000 00000000
00000006 000080C0 00000000 00000001
00000006 00008100 00000000 00000000
00000006 00007FC0 00000000 00000000
00000007 00300044 00000000 00000000
00000007 00100040 00000000 00000001
00000001 00000004 0000E000 00000000
00000004 43FFFFFC 00000001 00000001
00000004 44000000 00000001 00000000
00000001 00000004 00000000 00000000
00000004 00100FFC 00000001 00000000
00000000 00000000 00000000 00000000

/* verification/mmu_top_tb.sv */
`timescale 1ns/100ps

module mmu_top_tb
  import mmu_pkg::*;
();

  localparam int WAIT_LIMIT = 50;                     // Cycles per wait loop
  localparam int VEC_DEPTH  = 256;                    // Max vectors

  logic      nGCLK;
  logic      nRESET;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic      i_req;
  logic      d_req;
  logic      imiss;
  logic      dmiss;
  logic      dwb;
  addr_t     ia;
  addr_t     da;
  addr_t     imiss_addr;
  addr_t     dmiss_addr;
  addr_t     mma;
  logic      big_end;
  logic      iabort;
  logic      dabort;
  logic      use_mini;
  logic      stall;
  logic      mm_wr_n;
  logic      mm_new_line;
  logic      ic_read_mmd;
  logic      dc_read_mmd;
  logic      drive_mmd;
  word_t     vec_mem [0:VEC_DEPTH*4-1];               // Four words per vector
  int        errors;
  int        timeouts;

  mmu_top i_dut (.*);

  initial
    nGCLK = 1'b0;
  always
    #2 nGCLK = ~nGCLK;                                // 4 ns period

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic write_reg(input addr_t addr, input word_t data,
                           output logic [1:0] resp, output bit done);
    int waited;
    bit accepted;
    resp = 2'bxx;
    done = 1'b0;
    @(posedge nGCLK);
    axil_req.aw_valid <= 1'b1;
    axil_req.aw_addr  <= addr;
    axil_req.w_valid  <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= 4'hF;
    waited = 0;
    do
    begin
      @(negedge nGCLK);
      waited++;
    end
    while (!(axil_rsp.aw_ready && axil_rsp.w_ready) && waited < WAIT_LIMIT);
    accepted = axil_rsp.aw_ready && axil_rsp.w_ready;
    @(posedge nGCLK);                                 // Handshake edge
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    if (!accepted)
    begin
      timeouts++;
      $display("Write to %h was never accepted", addr);
    end
    else
    begin
      axil_req.b_ready <= 1'b1;
      waited = 0;
      do
      begin
        @(negedge nGCLK);
        waited++;
      end
      while (!axil_rsp.b_valid && waited < WAIT_LIMIT);
      if (axil_rsp.b_valid)
      begin
        resp = axil_rsp.b_resp;
        done = 1'b1;
      end
      else
      begin
        timeouts++;
        $display("No write response for %h", addr);
      end
      @(posedge nGCLK);
      axil_req.b_ready <= 1'b0;
    end
  endtask

  task automatic read_reg(input addr_t addr, output word_t data,
                          output logic [1:0] resp, output bit done);
    int waited;
    bit accepted;
    data = 'x;
    resp = 2'bxx;
    done = 1'b0;
    @(posedge nGCLK);
    axil_req.ar_valid <= 1'b1;
    axil_req.ar_addr  <= addr;
    waited = 0;
    do
    begin
      @(negedge nGCLK);
      waited++;
    end
    while (!axil_rsp.ar_ready && waited < WAIT_LIMIT);
    accepted = axil_rsp.ar_ready;
    @(posedge nGCLK);
    axil_req.ar_valid <= 1'b0;
    if (!accepted)
    begin
      timeouts++;
      $display("Read of %h was never accepted", addr);
    end
    else
    begin
      axil_req.r_ready <= 1'b1;
      waited = 0;
      do
      begin
        @(negedge nGCLK);
        waited++;
      end
      while (!axil_rsp.r_valid && waited < WAIT_LIMIT);
      if (axil_rsp.r_valid)
      begin
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        done = 1'b1;
      end
      else
      begin
        timeouts++;
        $display("No read data for %h", addr);
      end
      @(posedge nGCLK);
      axil_req.r_ready <= 1'b0;
    end
  endtask

  // Address is latched on the second edge
  task automatic latch_fetch(input addr_t addr);
    @(posedge nGCLK);
    i_req <= 1'b1;
    ia    <= addr;
    @(posedge nGCLK);
    i_req <= 1'b0;
  endtask

  task automatic latch_data(input addr_t addr);
    @(posedge nGCLK);
    d_req <= 1'b1;
    da    <= addr;
    @(posedge nGCLK);
    d_req <= 1'b0;
  endtask

  task automatic run_fetch_miss(input addr_t addr, input logic miss, input logic exp);
    latch_fetch(addr);
    imiss      <= miss;
    imiss_addr <= addr;
    @(negedge nGCLK);
    check_flag("iabort", iabort, exp);
    @(posedge nGCLK);
    imiss <= 1'b0;
  endtask

  task automatic run_data_miss(input addr_t addr, input logic miss, input logic exp);
    latch_data(addr);
    dmiss      <= miss;
    dmiss_addr <= addr;
    @(negedge nGCLK);
    check_flag("dabort", dabort, exp);
    @(posedge nGCLK);                                 // Fault captured here
    dmiss <= 1'b0;
  endtask

  task automatic run_fill(input addr_t addr, input logic aborted);
    int    waited;
    int    nl_cnt;
    int    rd_cnt;
    addr_t base;
    addr_t exp_mma;
    base = addr & ~addr_t'(LINE_WORDS*4 - 1);         // Line base
    latch_fetch(addr);
    imiss      <= 1'b1;
    imiss_addr <= addr;
    @(negedge nGCLK);
    check_flag("iabort", iabort, aborted);
    check_flag("stall", stall, !aborted);             // Same cycle as miss
    if (aborted)
    begin
      repeat (FILL_PENALTY + 4)
      begin
        check_flag("mm_new_line", mm_new_line, 1'b0);
        check_flag("ic_read_mmd", ic_read_mmd, 1'b0);
        check_flag("stall", stall, 1'b0);
        @(negedge nGCLK);
      end
    end
    else
    begin
      nl_cnt = 0;
      rd_cnt = 0;
      waited = 0;
      while (rd_cnt < LINE_WORDS && waited < WAIT_LIMIT)
      begin
        if (mm_new_line)
          nl_cnt++;
        if (ic_read_mmd || rd_cnt > 0)                // Strobe must stay up
        begin
          // Counter sits one past the latency at the first strobe
          exp_mma = base + addr_t'(4 * ((rd_cnt + FILL_LATENCY + 1) % LINE_WORDS));
          check_flag("ic_read_mmd", ic_read_mmd, 1'b1);
          check_word("mma", mma, exp_mma);
          rd_cnt++;
        end
        if (rd_cnt < LINE_WORDS)
        begin
          @(negedge nGCLK);
          waited++;
        end
      end
      if (rd_cnt < LINE_WORDS)
      begin
        timeouts++;
        $display("Line fill for %h never delivered eight words", addr);
      end
      check_word("mm_new_line count", nl_cnt, 1);
    end
    @(posedge nGCLK);
    imiss <= 1'b0;
    @(negedge nGCLK);
    check_flag("mm_new_line", mm_new_line, 1'b0);     // No second line
    check_flag("ic_read_mmd", ic_read_mmd, 1'b0);
  endtask

  initial
  begin
    int         idx;
    int         n_vec;
    word_t      op;
    word_t      arg_a;
    word_t      arg_b;
    word_t      arg_c;
    word_t      rdata;
    logic [1:0] resp;
    bit         done;
    errors     = 0;
    timeouts   = 0;
    void'($urandom(4000));                            // Fixed seed
    nRESET     = 1'b0;
    axil_req   = '0;
    i_req      = 1'b0;
    d_req      = 1'b0;
    imiss      = 1'b0;
    dmiss      = 1'b0;
    dwb        = 1'b0;
    ia         = '0;
    da         = '0;
    imiss_addr = '0;
    dmiss_addr = '0;
    $readmemh("verification/mmu_vectors.txt", vec_mem);
    repeat (15) @(posedge nGCLK);
    @(negedge nGCLK);                                 // Outputs held in reset
    check_flag("stall", stall, 1'b0);
    check_flag("mm_new_line", mm_new_line, 1'b0);
    check_flag("ic_read_mmd", ic_read_mmd, 1'b0);
    check_flag("dc_read_mmd", dc_read_mmd, 1'b0);
    check_flag("drive_mmd", drive_mmd, 1'b0);
    check_flag("iabort", iabort, 1'b0);
    check_flag("dabort", dabort, 1'b0);
    check_flag("use_mini", use_mini, 1'b0);
    check_flag("mm_wr_n", mm_wr_n, 1'b1);
    check_flag("b_valid", axil_rsp.b_valid, 1'b0);
    check_flag("r_valid", axil_rsp.r_valid, 1'b0);
    check_flag("big_end", big_end, 1'b0);
    @(posedge nGCLK);
    nRESET <= 1'b1;                                   // 16th edge
    idx   = 0;
    n_vec = 0;
    while (idx < VEC_DEPTH && !$isunknown(vec_mem[4*idx]) && vec_mem[4*idx] != 0)
    begin
      op    = vec_mem[4*idx];
      arg_a = vec_mem[4*idx + 1];
      arg_b = vec_mem[4*idx + 2];
      arg_c = vec_mem[4*idx + 3];
      case (op)
        1:
        begin
          write_reg(arg_a, arg_b, resp, done);
          if (done)
            check_resp("b_resp", resp, arg_c[1:0]);
        end
        2:
        begin
          read_reg(arg_a, rdata, resp, done);
          if (done)
          begin
            check_word("r_data", rdata, arg_b);
            check_resp("r_resp", resp, arg_c[1:0]);
          end
        end
        3:
        begin
          @(negedge nGCLK);
          check_flag("big_end", big_end, arg_c[0]);
        end
        4: run_fetch_miss(arg_a, arg_b[0], arg_c[0]);
        5: run_data_miss(arg_a, arg_b[0], arg_c[0]);
        6:
        begin
          latch_fetch(arg_a);
          @(negedge nGCLK);
          check_flag("use_mini", use_mini, arg_c[0]);
        end
        7: run_fill(arg_a, arg_c[0]);
        default:
        begin
          errors++;
          $display("Vector %0d has an unknown operation code %h", idx, op);
        end
      endcase
      repeat ($urandom_range(3)) @(posedge nGCLK);    // Idle gap
      idx++;
      n_vec++;
    end
    if (n_vec == 0)
    begin
      errors++;
      $display("No vectors were read from verification/mmu_vectors.txt");
    end
    $display("errors %0d timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* source/mmu_top.sv */
`timescale 1ns/100ps

module mmu_top
  import mmu_pkg::*;
(
  input  logic      nGCLK,
  input  logic      nRESET,
  input  axil_req_t axil_req,                         // Register access
  output axil_rsp_t axil_rsp,
  input  logic      i_req,
  input  logic      d_req,
  input  addr_t     ia,
  input  addr_t     da,
  input  logic      imiss,
  input  logic      dmiss,
  input  logic      dwb,
  input  addr_t     imiss_addr,
  input  addr_t     dmiss_addr,
  output logic      big_end,                          // Core endianness
  output logic      iabort,
  output logic      dabort,
  output logic      use_mini,
  output logic      stall,
  output addr_t     mma,
  output logic      mm_wr_n,
  output logic      mm_new_line,
  output logic      ic_read_mmd,
  output logic      dc_read_mmd,
  output logic      drive_mmd
);

  mmu_cfg_t cfg;                                      // Decoded control regs
  logic     fault_valid;
  addr_t    fault_addr;

  assign big_end = cfg.big_end;

  cp15_regs i_cp15_regs (
    .nGCLK       (nGCLK),
    .nRESET      (nRESET),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .fault_valid (fault_valid),
    .fault_addr  (fault_addr),
    .cfg         (cfg)
  );

  abort_unit i_abort_unit (
    .nGCLK       (nGCLK),
    .nRESET      (nRESET),
    .stall       (stall),
    .i_req       (i_req),
    .d_req       (d_req),
    .imiss       (imiss),
    .dmiss       (dmiss),
    .ia          (ia),
    .da          (da),
    .cfg         (cfg),
    .iabort      (iabort),
    .dabort      (dabort),
    .use_mini    (use_mini),
    .fault_valid (fault_valid),
    .fault_addr  (fault_addr)
  );

  line_fill i_line_fill (
    .nGCLK       (nGCLK),
    .nRESET      (nRESET),
    .imiss       (imiss),
    .dmiss       (dmiss),
    .dwb         (dwb),
    .imiss_addr  (imiss_addr),
    .dmiss_addr  (dmiss_addr),
    .iabort      (iabort),
    .dabort      (dabort),
    .stall       (stall),
    .mma         (mma),
    .mm_wr_n     (mm_wr_n),
    .mm_new_line (mm_new_line),
    .ic_read_mmd (ic_read_mmd),
    .dc_read_mmd (dc_read_mmd),
    .drive_mmd   (drive_mmd)
  );

endmodule

/* source/line_fill.sv */
`timescale 1ns/100ps

module line_fill
  import mmu_pkg::*;
(
  input  logic  nGCLK,
  input  logic  nRESET,
  input  logic  imiss,                                // I-cache miss
  input  logic  dmiss,                                // D-cache miss
  input  logic  dwb,                                  // Dirty line write-back
  input  addr_t imiss_addr,
  input  addr_t dmiss_addr,
  input  logic  iabort,
  input  logic  dabort,
  output logic  stall,                                // Hold the core
  output addr_t mma,                                  // Main memory address
  output logic  mm_wr_n,                              // Low while writing back
  output logic  mm_new_line,                          // Start of line transfer
  output logic  ic_read_mmd,
  output logic  dc_read_mmd,
  output logic  drive_mmd                             // D-cache drives data out
);

  logic               go;                             // Miss being serviced
  logic               srv_d;                          // Serving D-cache side
  logic               dwb_q;                          // dwb one cycle late
  logic [COUNT_W-1:0] count;                          // Cycles into transfer
  logic [COUNT_W-1:0] next_count;
  logic [COUNT_W-1:0] penalty;                        // Last count of transfer
  logic               wb_window;                      // Write-back words out

  assign stall = (imiss & ~iabort) | (dmiss & ~dabort);

  // Write-back ends one latency after the last word
  assign penalty    = mm_wr_n ? COUNT_W'(FILL_PENALTY)
                              : COUNT_W'(LINE_WORDS - 1 + FILL_LATENCY);
  assign next_count = (count == penalty) ? '0 : count + 1'b1;
  assign wb_window  = dwb & go & (count < COUNT_W'(LINE_WORDS));

  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
    begin
      go      <= 1'b0;
      srv_d   <= 1'b0;
      dwb_q   <= 1'b0;
      count   <= '0;
      mm_wr_n <= 1'b1;
    end
    else
    begin
      go      <= stall;                               // Aborted misses never start
      srv_d   <= (dmiss & (count != penalty)) | dwb;
      dwb_q   <= dwb;
      mm_wr_n <= ~wb_window;
      if (stall & go)
        count <= next_count;
      else
        count <= '0;
    end
  end

  // Line base plus word offset from the counter
  assign mma = srv_d ? {dmiss_addr[31:5], count[2:0], 2'b00}
                     : {imiss_addr[31:5], count[2:0], 2'b00};

  // Data returns after the memory latency
  assign ic_read_mmd = (count > COUNT_W'(FILL_LATENCY)) & ~srv_d;
  assign dc_read_mmd = (count > COUNT_W'(FILL_LATENCY)) & srv_d & mm_wr_n & ~dwb_q;
  assign drive_mmd   = wb_window;

  // Read fill at count 0, or refill after write-back drains
  assign mm_new_line = (go & (count == '0) & mm_wr_n & ~dwb & (imiss | dmiss))
                     | (go & (count == COUNT_W'(LINE_WORDS)) & dwb & dmiss);

endmodule

/* source/abort_unit.sv */
`timescale 1ns/100ps

module abort_unit
  import mmu_pkg::*;
(
  input  logic     nGCLK,
  input  logic     nRESET,
  input  logic     stall,                             // Hold latched addresses
  input  logic     i_req,                             // Fetch request
  input  logic     d_req,                             // Data request
  input  logic     imiss,
  input  logic     dmiss,
  input  addr_t    ia,
  input  addr_t    da,
  input  mmu_cfg_t cfg,
  output logic     iabort,                            // Prefetch abort
  output logic     dabort,                            // Data abort
  output logic     use_mini,                          // Non-cacheable fetch
  output logic     fault_valid,
  output addr_t    fault_addr
);

  logic [IDR_TAG_W-1:0] ia_q;                         // Fetch addr[31:6]
  addr_t                da_q;                         // Full data address
  addr_t                ia_line;                      // Fetch addr, low bits zero
  logic [NUM_CBR-1:0]   i_hit;
  logic [NUM_CBR-1:0]   d_hit;
  logic [IDR_TAG_W-1:0] idr_mask;
  logic                 idr_hit;

  // Address latches, frozen while stalled
  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
    begin
      ia_q <= '0;
      da_q <= '0;
    end
    else if (!stall)
    begin
      if (i_req)
        ia_q <= ia[31:IDR_TAG_LSB];
      if (d_req)
        da_q <= da;
    end
  end

  assign ia_line = {ia_q, {IDR_TAG_LSB{1'b0}}};

  region_match i_inst_match (
    .addr    (ia_line),
    .regions (cfg.cbr),
    .hit     (i_hit)
  );

  region_match i_data_match (
    .addr    (da_q),
    .regions (cfg.cbr),
    .hit     (d_hit)
  );

  // Abort only a miss inside an enabled region
  assign iabort = imiss & |(i_hit & cfg.cbr_en);
  assign dabort = dmiss & |(d_hit & cfg.cbr_en);

  // Decompression routine compare at 64 B granule
  assign idr_mask = (IDR_TAG_W'(1) << cfg.idr.size) - IDR_TAG_W'(1);
  assign idr_hit  = ~|((ia_q ^ cfg.idr.tag) & ~idr_mask);
  assign use_mini = idr_hit & cfg.idrr_en;

  assign fault_valid = dabort;                        // Captured in FAULT reg
  assign fault_addr  = da_q;

endmodule

/* source/cp15_regs.sv */
`timescale 1ns/100ps

module cp15_regs
  import mmu_pkg::*;
(
  input  logic      nGCLK,
  input  logic      nRESET,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  logic      fault_valid,                      // Data abort this cycle
  input  addr_t     fault_addr,
  output mmu_cfg_t  cfg
);

  logic [3:0] wr_idx;                                 // Write register index
  logic [3:0] rd_idx;                                 // Read register index
  logic       wr_accept;                              // AW and W handshake
  logic       rd_accept;                              // AR handshake
  logic       b_valid_q;
  logic       r_valid_q;
  logic [1:0] b_resp_q;
  logic [1:0] r_resp_q;
  word_t      r_data_q;
  word_t      rd_word;                                // Read mux output
  word_t      ctrl_q;
  word_t      cbr_q [NUM_CBR];                        // Compression regions
  word_t      idr_q;
  word_t      fault_q;                                // Data fault address

  function automatic logic reg_mapped(input logic [3:0] idx);
    return idx inside {REG_ID, REG_CTRL, REG_CBR0, REG_CBR1, REG_CBR2,
                       REG_IDR, REG_FAULT};
  endfunction

  assign wr_idx    = axil_req.aw_addr[5:2];
  assign rd_idx    = axil_req.ar_addr[5:2];
  // Pending response holds off its own channel only
  assign wr_accept = axil_req.aw_valid & axil_req.w_valid & ~b_valid_q;
  assign rd_accept = axil_req.ar_valid & ~r_valid_q;

  // Register bank, full word writes
  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
    begin
      ctrl_q   <= CFG_RESET;
      cbr_q[0] <= CFG_RESET;
      cbr_q[1] <= CFG_RESET;
      cbr_q[2] <= CFG_RESET;
      idr_q    <= CFG_RESET;
      fault_q  <= CFG_RESET;
    end
    else
    begin
      if (wr_accept)
      begin
        case (wr_idx)
          REG_CTRL: ctrl_q   <= axil_req.w_data;
          REG_CBR0: cbr_q[0] <= axil_req.w_data;
          REG_CBR1: cbr_q[1] <= axil_req.w_data;
          REG_CBR2: cbr_q[2] <= axil_req.w_data;
          REG_IDR:  idr_q    <= axil_req.w_data;
          default:  ;                                 // ID and FAULT read-only
        endcase
      end
      if (fault_valid)
        fault_q <= fault_addr;                        // Capture aborting address
    end
  end

  always_comb
  begin
    case (rd_idx)
      REG_ID:    rd_word = ID_VALUE;
      REG_CTRL:  rd_word = ctrl_q;
      REG_CBR0:  rd_word = cbr_q[0];
      REG_CBR1:  rd_word = cbr_q[1];
      REG_CBR2:  rd_word = cbr_q[2];
      REG_IDR:   rd_word = idr_q;
      REG_FAULT: rd_word = fault_q;
      default:   rd_word = '0;                        // Unmapped reads zero
    endcase
  end

  // Response valid flags
  always_ff @(posedge nGCLK or negedge nRESET)
  begin
    if (!nRESET)
    begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end
    else
    begin
      if (wr_accept)
        b_valid_q <= 1'b1;
      else if (axil_req.b_ready)
        b_valid_q <= 1'b0;
      if (rd_accept)
        r_valid_q <= 1'b1;
      else if (axil_req.r_ready)
        r_valid_q <= 1'b0;
    end
  end

  // Response payload captured at each handshake
  always_ff @(posedge nGCLK)
  begin
    if (wr_accept)
      b_resp_q <= reg_mapped(wr_idx) ? RESP_OKAY : RESP_SLVERR;
    if (rd_accept)
    begin
      r_data_q <= rd_word;
      r_resp_q <= reg_mapped(rd_idx) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb
  begin
    axil_rsp.aw_ready = wr_accept;                    // One cycle pulse
    axil_rsp.w_ready  = wr_accept;
    axil_rsp.b_valid  = b_valid_q;
    axil_rsp.b_resp   = b_resp_q;
    axil_rsp.ar_ready = rd_accept;
    axil_rsp.r_valid  = r_valid_q;
    axil_rsp.r_data   = r_data_q;
    axil_rsp.r_resp   = r_resp_q;
  end

  // Decoded configuration fields
  always_comb
  begin
    cfg.big_end   = ctrl_q[CTRL_BIG_END];
    cfg.cbr_en    = {ctrl_q[CTRL_CBR2_EN], ctrl_q[CTRL_CBR1_EN], ctrl_q[CTRL_CBR0_EN]};
    cfg.idrr_en   = ctrl_q[CTRL_IDRR_EN];
    for (int i = 0; i < NUM_CBR; i++)
    begin
      cfg.cbr[i].tag  = cbr_q[i][31:CBR_TAG_LSB];
      cfg.cbr[i].size = cbr_q[i][3:0];
    end
    cfg.idr.tag   = idr_q[31:IDR_TAG_LSB];
    cfg.idr.size  = idr_q[1:0];
  end

endmodule

/* source/region_match.sv */
`timescale 1ns/100ps

module region_match
  import mmu_pkg::*;
(
  input  addr_t                  addr,                // Address under test
  input  region_t [NUM_CBR-1:0]  regions,
  output logic    [NUM_CBR-1:0]  hit                  // Per region, no enable
);

  logic [CBR_TAG_W-1:0] addr_tag;                     // addr[31:11]
  logic [CBR_TAG_W-1:0] mask [NUM_CBR];               // Low tag bits ignored
  logic [CBR_TAG_W-1:0] diff [NUM_CBR];               // Tag mismatch bits

  assign addr_tag = addr[31:CBR_TAG_LSB];

  always_comb
  begin
    for (int i = 0; i < NUM_CBR; i++)
    begin
      // Size code n ignores the n lowest tag bits
      mask[i] = (CBR_TAG_W'(1) << regions[i].size) - CBR_TAG_W'(1);
      diff[i] = addr_tag ^ regions[i].tag;
      hit[i]  = ~|(diff[i] & ~mask[i]);               // Match above the mask
    end
  end

endmodule

/* source/mmu_pkg.sv */
package mmu_pkg;

  typedef logic [31:0] addr_t;                        // Byte address
  typedef addr_t       word_t;                        // Register data word

  localparam int NUM_CBR     = 3;                     // Compression regions
  localparam int CBR_TAG_LSB = 11;                    // 2 KB granule
  localparam int CBR_TAG_W   = 32 - CBR_TAG_LSB;      // Tag is addr[31:11]
  localparam int IDR_TAG_LSB = 6;                     // 64 byte granule
  localparam int IDR_TAG_W   = 32 - IDR_TAG_LSB;      // Tag is addr[31:6]

  // Register index, taken from addr[5:2]
  localparam logic [3:0] REG_ID    = 4'd0;
  localparam logic [3:0] REG_CTRL  = 4'd1;
  localparam logic [3:0] REG_CBR0  = 4'd2;
  localparam logic [3:0] REG_CBR1  = 4'd3;
  localparam logic [3:0] REG_CBR2  = 4'd4;
  localparam logic [3:0] REG_IDR   = 4'd5;
  localparam logic [3:0] REG_FAULT = 4'd14;

  localparam word_t ID_VALUE  = 32'hED01_9ED0;        // Read-only ID
  localparam word_t CFG_RESET = '0;                   // All config regs clear

  localparam int CTRL_BIG_END = 7;                    // Big endian select
  localparam int CTRL_CBR0_EN = 13;
  localparam int CTRL_CBR1_EN = 14;
  localparam int CTRL_CBR2_EN = 15;
  localparam int CTRL_IDRR_EN = 16;                   // Decomp routine enable

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam int LINE_WORDS   = 8;                    // Words per cache line
  localparam int FILL_LATENCY = 1;                    // Memory latency, cycles
  localparam int FILL_PENALTY = FILL_LATENCY + LINE_WORDS;
  localparam int COUNT_W      = 4;

  typedef struct packed {
    logic [CBR_TAG_W-1:0] tag;                        // Region base addr[31:11]
    logic [3:0]           size;                       // 0 = 2 KB .. 15 = 64 MB
  } region_t;

  typedef struct packed {
    logic [IDR_TAG_W-1:0] tag;                        // Routine base addr[31:6]
    logic [1:0]           size;                       // 0 = 64 B .. 3 = 512 B
  } idr_t;

  typedef struct packed {
    logic                      big_end;
    logic    [NUM_CBR-1:0]     cbr_en;
    logic                      idrr_en;
    region_t [NUM_CBR-1:0]     cbr;
    idr_t                      idr;
  } mmu_cfg_t;

  typedef struct packed {
    logic       aw_valid;
    addr_t      aw_addr;
    logic       w_valid;
    word_t      w_data;
    logic [3:0] w_strb;
    logic       b_ready;
    logic       ar_valid;
    addr_t      ar_addr;
    logic       r_ready;
  } axil_req_t;

  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    logic [1:0] b_resp;
    logic       ar_ready;
    logic       r_valid;
    word_t      r_data;
    logic [1:0] r_resp;
  } axil_rsp_t;

endpackage
